/* verilog/img_pkg.sv */
`default_nettype none

package img_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int IMG_W = 320;
    localparam int IMG_H = 240;
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [8:0]       col_t;     // 0 .. IMG_W-1.
    typedef logic [7:0]       row_t;     // counts up to IMG_H+1 during the flush.

    // a pixel at or above this level counts as white for erosion.
    localparam pix_t BIN_THRESH = 8'd128;

endpackage

`default_nettype wire

/* verilog/filt_pkg.sv */
`default_nettype none

package filt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // filter arithmetic.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int N_TAPS = 9;

    typedef logic signed [7:0] coef_t;

    // 9 * 128 * 255 fits comfortably below 2**20.
    localparam int ACC_W = 21;
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam int GAUSS_SHIFT = 4;

    typedef enum logic [1:0] {
        MODE_CONV  = 2'd0,
        MODE_GAUSS = 2'd1,
        MODE_ERODE = 2'd2      // code 3 falls back to plain convolution.
    } mode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_COEF0 = 8'h00;   // coefficient k at ADDR_COEF0 + 4*k.
    localparam logic [APB_AW-1:0] ADDR_MODE  = 8'h24;

endpackage

`default_nettype wire

/* verilog/filt_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module filt_apb_regs
    import filt_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output coef_t             coef_o [N_TAPS],
    output mode_t             mode_o
);

    logic              access;
    logic              coef_hit;
    logic              mode_hit;
    logic [APB_AW-1:0] coef_off;
    logic [3:0]        coef_idx;

    assign access   = psel_i & penable_i;
    assign coef_off = paddr_i - ADDR_COEF0;
    assign coef_hit = (coef_off[1:0] == 2'b00) && (coef_off[APB_AW-1:2] < N_TAPS);
    assign coef_idx = coef_off[5:2];
    assign mode_hit = (paddr_i == ADDR_MODE);

    assign pready_o  = 1'b1;                              // no wait states.
    assign pslverr_o = access & ~(coef_hit | mode_hit);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < N_TAPS; k++) begin
                coef_o[k] <= '0;
            end
            mode_o <= MODE_CONV;
        end else if (access && pwrite_i) begin
            if (coef_hit) begin
                coef_o[coef_idx] <= coef_t'(pwdata_i[7:0]);
            end
            if (mode_hit) begin
                mode_o <= mode_t'(pwdata_i[1:0]);
            end
        end
    end

    // read data is combinational; the access phase is a single cycle.
    always_comb begin
        prdata_o = '0;
        if (coef_hit) begin
            prdata_o = {{(APB_DW-8){coef_o[coef_idx][7]}}, coef_o[coef_idx]};
        end else if (mode_hit) begin
            prdata_o = {{(APB_DW-2){1'b0}}, mode_o};
        end
    end

endmodule

`default_nettype wire

/* verilog/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer
    import img_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic pix_valid_i,
    input  pix_t pix_i,
    output logic col_valid_o,
    output pix_t col_top_o,
    output pix_t col_mid_o,
    output pix_t col_bot_o,
    output logic col_first_o
);

    col_t col_q;
    row_t row_q;
    logic sel_q;                  // memory holding row r-1; the other one holds row r-2.
    pix_t mem_q [2][IMG_W];

    logic flushing;
    logic beat;
    logic top_ok;
    logic mid_ok;
    logic bot_ok;

    // rows IMG_H and IMG_H+1 are generated here without input pixels.
    assign flushing = (row_q >= IMG_H);
    assign beat     = flushing || pix_valid_i;

    assign top_ok = (row_q >= 2) && (row_q <= IMG_H);
    assign mid_ok = (row_q <= IMG_H);
    assign bot_ok = (row_q < IMG_H);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            col_q       <= '0;
            row_q       <= '0;
            sel_q       <= 1'b0;
            col_valid_o <= 1'b0;
        end else begin
            col_valid_o <= beat && (row_q != '0);   // row 0 has nothing above it yet.
            if (beat) begin
                if (row_q == IMG_H + 1) begin
                    col_q <= '0;
                    row_q <= '0;
                end else if (col_q == IMG_W - 1) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                    sel_q <= ~sel_q;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // the old row is read out in the same cycle that overwrites it.
    always_ff @(posedge clk_i) begin
        if (beat && bot_ok) begin
            mem_q[~sel_q][col_q] <= pix_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat) begin
            col_top_o   <= top_ok ? mem_q[~sel_q][col_q] : '0;
            col_mid_o   <= mid_ok ? mem_q[sel_q][col_q] : '0;
            col_bot_o   <= bot_ok ? pix_i : '0;
            col_first_o <= (col_q == '0);
        end
    end

endmodule

`default_nettype wire

/* verilog/window_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module window_shift
    import img_pkg::*;
    import filt_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic col_valid_i,
    input  pix_t col_top_i,
    input  pix_t col_mid_i,
    input  pix_t col_bot_i,
    input  logic col_first_i,
    output logic win_valid_o,
    output pix_t win_o [N_TAPS]       // tap 3*row + col, row 0 on top, col 0 on the left.
);

    pix_t col_in [3];
    pix_t left_q [3];
    pix_t ctr_q  [3];
    logic have_row_q;                 // a row of centres is pending behind the next column 0.

    assign col_in[0] = col_top_i;
    assign col_in[1] = col_mid_i;
    assign col_in[2] = col_bot_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            win_valid_o <= 1'b0;
            have_row_q  <= 1'b0;
        end else begin
            win_valid_o <= col_valid_i && (!col_first_i || have_row_q);
            if (col_valid_i) begin
                have_row_q <= !col_first_i;
            end
        end
    end

    // a column-0 beat closes the previous row with a zero right column
    // and starts the next one with a zero left column.
    always_ff @(posedge clk_i) begin
        if (col_valid_i) begin
            for (int r = 0; r < 3; r++) begin
                win_o[3*r]     <= left_q[r];
                win_o[3*r + 1] <= ctr_q[r];
                win_o[3*r + 2] <= col_first_i ? '0 : col_in[r];
                left_q[r]      <= col_first_i ? '0 : ctr_q[r];
                ctr_q[r]       <= col_in[r];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/conv_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac
    import img_pkg::*;
    import filt_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  win_valid_i,
    input  pix_t  win_i [N_TAPS],
    input  coef_t coef_i [N_TAPS],
    output logic  acc_valid_o,
    output acc_t  acc_o,
    output logic  all_high_o
);

    acc_t sum;
    logic high;

    always_comb begin
        sum  = '0;
        high = 1'b1;
        for (int k = 0; k < N_TAPS; k++) begin
            // pixels are unsigned, so they widen with zeros.
            sum  = sum + acc_t'(coef_i[k]) * acc_t'(win_i[k]);
            high = high & (win_i[k] >= BIN_THRESH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            acc_valid_o <= 1'b0;
        end else begin
            acc_valid_o <= win_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            acc_o      <= sum;
            all_high_o <= high;
        end
    end

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import img_pkg::*;
    import filt_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  acc_valid_i,
    input  acc_t  acc_i,
    input  logic  all_high_i,
    input  mode_t mode_i,
    output logic  res_valid_o,
    output pix_t  res_o
);

    acc_t scaled;
    pix_t clamped;
    pix_t res_d;

    always_comb begin
        scaled = (mode_i == MODE_GAUSS) ? (acc_i >>> GAUSS_SHIFT) : acc_i;

        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > acc_t'({PIX_W{1'b1}})) begin
            clamped = '1;                                  // saturate at full white.
        end else begin
            clamped = scaled[PIX_W-1:0];
        end

        res_d = clamped;
        if (mode_i == MODE_ERODE) begin
            res_d = all_high_i ? '1 : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= acc_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (acc_valid_i) begin
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_engine
    import img_pkg::*;
    import filt_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    input  logic              pix_valid_i,
    input  pix_t              pix_i,
    output logic              res_valid_o,
    output pix_t              res_o
);

    coef_t coef [N_TAPS];
    mode_t mode;

    logic  col_valid;
    pix_t  col_top;
    pix_t  col_mid;
    pix_t  col_bot;
    logic  col_first;
    logic  win_valid;
    pix_t  win [N_TAPS];
    logic  acc_valid;
    acc_t  acc;
    logic  all_high;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    filt_apb_regs u_regs (
        .clk_i, .rstn_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o, .coef_o(coef), .mode_o(mode)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel pipeline.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    line_buffer u_lines (
        .clk_i, .rstn_i, .pix_valid_i, .pix_i,
        .col_valid_o(col_valid), .col_top_o(col_top), .col_mid_o(col_mid),
        .col_bot_o(col_bot), .col_first_o(col_first)
    );

    window_shift u_window (
        .clk_i, .rstn_i, .col_valid_i(col_valid), .col_top_i(col_top),
        .col_mid_i(col_mid), .col_bot_i(col_bot), .col_first_i(col_first),
        .win_valid_o(win_valid), .win_o(win)
    );

    conv_mac u_mac (
        .clk_i, .rstn_i, .win_valid_i(win_valid), .win_i(win), .coef_i(coef),
        .acc_valid_o(acc_valid), .acc_o(acc), .all_high_o(all_high)
    );

    result_stage u_result (
        .clk_i, .rstn_i, .acc_valid_i(acc_valid), .acc_i(acc), .all_high_i(all_high),
        .mode_i(mode), .res_valid_o, .res_o
    );

endmodule

`default_nettype wire

/* test/tb_conv_tasks.svh */
`ifndef TB_CONV_TASKS_SVH
`define TB_CONV_TASKS_SVH

// one xorshift32 step per call.
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
        err_value++;
        $display("ERR %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB master.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// called 2 ns after a rising edge; returns at the same offset.
task automatic bus_transfer(input logic [7:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #10;                                  // middle of the access phase.
    assert (pready === 1'b1) else begin
        err_other++;
        $display("pready was low during the access phase at address %0h", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    logic        err;
    bus_transfer(addr, 1'b1, data, unused, err);
    check_value("pslverr on write", exp_err, err);
endtask

task automatic read_reg(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
    logic err;
    bus_transfer(addr, 1'b0, '0, data, err);
    check_value("pslverr on read", exp_err, err);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic int pixel_at(input int r, input int c);
    if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
        return 0;                         // outside the frame reads as black.
    end
    return int'(frame[r][c]);
endfunction

task automatic build_expected(input int mode);
    int  sum;
    int  p;
    int  v;
    bit  high;
    for (int r = 0; r < IMG_H; r++) begin
        for (int c = 0; c < IMG_W; c++) begin
            sum  = 0;
            high = 1'b1;
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    p    = pixel_at(r + dr, c + dc);
                    sum  = sum + coef_val[3*(dr + 1) + dc + 1] * p;
                    high = high && (p >= 128);
                end
            end
            if (mode == 2) begin
                v = high ? 255 : 0;
            end else begin
                v = (mode == 1) ? (sum >>> 4) : sum;
                if (v < 0) v = 0;
                if (v > 255) v = 255;
            end
            expected.push_back(v);
        end
    end
endtask

`endif

/* test/tb_conv_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_engine
    import img_pkg::*;
    import filt_pkg::*;
();

    localparam int CYCLE_LIMIT = 3 * (2*IMG_W*IMG_H + IMG_W + 50) + 200;
    localparam int DRAIN_LIMIT = 2*IMG_W + 50;

    logic              clk;
    logic              rstn;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              pix_valid;
    pix_t              pix;
    logic              res_valid;
    pix_t              res;

    logic [31:0] rng_state = 32'd52;
    pix_t        frame [IMG_H][IMG_W];
    int          coef_val [N_TAPS];
    int          expected [$];
    string       test_name = "reset";
    int          checks;
    int          err_value;
    int          err_other;
    int          cycles;

    `include "tb_conv_tasks.svh"

    conv_engine dut_i (
        .clk_i(clk), .rstn_i(rstn), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .pix_valid_i(pix_valid), .pix_i(pix),
        .res_valid_o(res_valid), .res_o(res)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in %s, the run did not finish", cycles, test_name);
            $display("Regression failed");
            $finish;
        end
    end

    // every result is compared with the head of the model queue.
    always @(posedge clk) begin
        if (rstn && res_valid) begin
            assert (expected.size() != 0) else begin
                err_other++;
                $display("a result arrived in %s while no result was pending", test_name);
            end
            if (expected.size() != 0) begin
                check_value("pixel", expected.pop_front(), res);
            end
        end
    end

    task automatic load_coefs(input bit non_negative);
        logic [31:0] r;
        for (int k = 0; k < N_TAPS; k++) begin
            r = next_rand();
            coef_val[k] = non_negative ? int'(r[1:0]) : int'($signed(r[7:0]));
            write_reg(ADDR_COEF0 + 8'(4*k), 32'(coef_val[k]), 1'b0);
        end
    endtask

    task automatic fill_frame(input bit biased);
        logic [31:0] r;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                r = next_rand();
                frame[y][x] = (biased && r[10:8] != 3'd0) ? {1'b1, r[6:0]} : r[7:0];
            end
        end
    endtask

    task automatic stream_frame();
        int waited;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                while (next_rand() % 4 == 0) begin     // roughly one gap in four.
                    pix_valid = 1'b0;
                    @(posedge clk);
                    #2;
                end
                pix_valid = 1'b1;
                pix       = frame[y][x];
                @(posedge clk);
                #2;
            end
        end
        pix_valid = 1'b0;
        waited    = 0;
        while (expected.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (expected.size() == 0) else begin
            err_other++;
            $display("%0d results of %s never arrived", expected.size(), test_name);
        end
        expected.delete();
        repeat (IMG_W + 8) @(posedge clk);           // late extra results show up here.
        #2;
    endtask

    task automatic run_frame(input string name, input int mode, input bit non_negative,
                             input bit biased);
        test_name = name;
        load_coefs(non_negative);
        write_reg(ADDR_MODE, 32'(mode), 1'b0);
        fill_frame(biased);
        build_expected(mode);
        stream_frame();
    endtask

    initial begin
        logic [31:0] data;
        int          mode_val;
        clk       = 1'b0;
        rstn      = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pix_valid = 1'b0;
        pix       = '0;
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // register access.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        test_name = "apb_access";
        load_coefs(1'b0);
        mode_val = next_rand() % 3;
        write_reg(ADDR_MODE, 32'(mode_val), 1'b0);
        for (int k = 0; k < N_TAPS; k++) begin
            read_reg(ADDR_COEF0 + 8'(4*k), 1'b0, data);
            check_value("coefficient", 32'(coef_val[k]), data);   // sign-extended.
        end
        read_reg(ADDR_MODE, 1'b0, data);
        check_value("mode", 32'(mode_val), data);

        test_name = "apb_unmapped";
        write_reg(8'h40, 32'h3, 1'b1);
        read_reg(8'h40, 1'b1, data);
        read_reg(ADDR_MODE, 1'b0, data);
        check_value("mode after bad write", 32'(mode_val), data);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // frames.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        run_frame("mode_conv", 0, 1'b0, 1'b0);
        run_frame("mode_gauss", 1, 1'b1, 1'b0);
        run_frame("mode_erode", 2, 1'b0, 1'b1);

        $display("checks %0d, value errors %0d, other errors %0d", checks, err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv_engine.f */
+incdir+test
verilog/img_pkg.sv
verilog/filt_pkg.sv
verilog/filt_apb_regs.sv
verilog/line_buffer.sv
verilog/window_shift.sv
verilog/conv_mac.sv
verilog/result_stage.sv
verilog/conv_engine.sv
test/tb_conv_engine.sv

/* Bender.yml */
package:
  name: conv_engine

sources:
  - verilog/img_pkg.sv
  - verilog/filt_pkg.sv
  - verilog/filt_apb_regs.sv
  - verilog/line_buffer.sv
  - verilog/window_shift.sv
  - verilog/conv_mac.sv
  - verilog/result_stage.sv
  - verilog/conv_engine.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_conv_engine.sv
